/* common/sgdma_pkg.sv */
package sgdma_pkg;

    ////////////////////
    // widths
    ////////////////////

    // FIFO and memory word
    localparam int DATA_W = 32;
    // sram cell address, bits 15:12 pick the sram
    localparam int ADDR_W = 16;
    // words per packet, header included
    localparam int CNT_W = 7;
    localparam int PORT_W = 4;
    localparam int DISP_W = 30;
    // whatever the dispatch word has left after address and count
    localparam int QOS_W = DISP_W - ADDR_W - CNT_W;

    ////////////////////
    // header layout
    ////////////////////

    // byte length field
    localparam int LEN_LSB = 7;
    localparam int LEN_MSB = 17;
    localparam int LEN_W = LEN_MSB - LEN_LSB + 1;
    // one data word carries one cell
    localparam int CELL_BYTES = 16;

    ////////////////////
    // free list
    ////////////////////

    localparam int FL_DEPTH = 128;
    localparam int FL_PTR_W = $clog2(FL_DEPTH);
    // one slot stays unused so init never fills the FIFO
    localparam int FL_INIT_CNT = 127;

    ////////////////////
    // types
    ////////////////////

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [CNT_W-1:0] cell_cnt_t;
    typedef logic [PORT_W-1:0] port_id_t;

    // crossbar scheduling word, head address first
    typedef struct packed {
        addr_t            first_addr;
        cell_cnt_t        cells;
        logic [QOS_W-1:0] qos;
    } dispatch_t;

    // packet store FSM
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_REQ,
        ST_HEAD,
        ST_BODY,
        ST_DONE
    } store_state_e;

    // free list refill request
    typedef enum logic [1:0] {
        RF_IDLE,
        RF_ISSUE,
        RF_WAIT
    } refill_state_e;

endpackage

/* free_list/free_ptr_fifo.sv */
`timescale 1ns/1ps

module free_ptr_fifo (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_push,
    input  sgdma_pkg::addr_t  i_push_addr,
    input  logic              i_pop,
    output sgdma_pkg::addr_t  o_head,
    output logic              o_full,
    output logic              o_empty
);

    sgdma_pkg::addr_t               mem [sgdma_pkg::FL_DEPTH];
    // depth is a power of two, pointers wrap on their own
    logic [sgdma_pkg::FL_PTR_W-1:0] wr_ptr_q;
    logic [sgdma_pkg::FL_PTR_W-1:0] rd_ptr_q;
    logic [sgdma_pkg::FL_PTR_W:0]   fill_q;
    logic                           do_push;
    logic                           do_pop;

    assign o_full  = (fill_q == (sgdma_pkg::FL_PTR_W + 1)'(sgdma_pkg::FL_DEPTH));
    assign o_empty = (fill_q == '0);
    // fall-through read
    assign o_head  = mem[rd_ptr_q];

    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= i_push_addr;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            fill_q   <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // push and pop together leave the fill alone
            case ({do_push, do_pop})
                2'b10:   fill_q <= fill_q + 1'b1;
                2'b01:   fill_q <= fill_q - 1'b1;
                default: fill_q <= fill_q;
            endcase
        end
    end

    a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_pop |-> !o_empty);

    a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_push |-> !o_full);

endmodule

/* free_list/free_list_init.sv */
`timescale 1ns/1ps

module free_list_init #(
    parameter sgdma_pkg::port_id_t PORT_ID = '0
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_locked,
    input  logic              i_fp_full,
    input  logic              i_fp_wr_en,
    input  sgdma_pkg::addr_t  i_fp_wr_dat,
    output logic              o_push,
    output sgdma_pkg::addr_t  o_push_addr
);

    // next index to hand out
    sgdma_pkg::cell_cnt_t cnt_q;
    logic                 done_q;
    sgdma_pkg::addr_t     init_addr;

    // sram number on top, index at the bottom, middle bits zero
    always_comb begin
        init_addr = '0;
        init_addr[sgdma_pkg::ADDR_W-1 -: sgdma_pkg::PORT_W] = PORT_ID;
        init_addr[sgdma_pkg::CNT_W-1:0] = cnt_q;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt_q  <= '0;
            done_q <= 1'b0;
            o_push <= 1'b0;
        end else if (done_q) begin
            // recycled pointers only from here on
            o_push <= i_fp_wr_en;
        end else if (!i_locked) begin
            // clock lost mid-init, start over
            cnt_q  <= '0;
            o_push <= 1'b0;
        end else if (!i_fp_full) begin
            o_push <= 1'b1;
            cnt_q  <= cnt_q + sgdma_pkg::cell_cnt_t'(1);
            if (cnt_q == sgdma_pkg::cell_cnt_t'(sgdma_pkg::FL_INIT_CNT - 1)) begin
                done_q <= 1'b1;
            end
        end else begin
            o_push <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        o_push_addr <= done_q ? i_fp_wr_dat : init_addr;
    end

    // free FIFO must have room for every address in flight
    a_push_not_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_push |-> !i_fp_full);

endmodule

/* hdl/cell_store_fsm.sv */
`timescale 1ns/1ps

module cell_store_fsm (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_locked,
    input  sgdma_pkg::data_t      i_dat,
    input  logic                  i_empty,
    input  logic                  i_cb_full,
    input  logic                  i_mmu_wr_ready,
    input  sgdma_pkg::addr_t      i_fp_head,
    input  logic                  i_fp_empty,
    output logic                  o_rd_en,
    output logic                  o_fp_pop,
    output sgdma_pkg::dispatch_t  o_cb_din,
    output logic                  o_cb_wr_en,
    output logic                  o_mmu_wr_req,
    output logic                  o_mmu_wr_en,
    output sgdma_pkg::addr_t      o_mmu_wr_addr,
    output sgdma_pkg::data_t      o_mmu_wr_dat,
    output logic                  o_mmu_wr_done,
    output logic                  o_hdr_stored,
    output sgdma_pkg::cell_cnt_t  o_total_cells
);

    sgdma_pkg::store_state_e       state_q;
    sgdma_pkg::store_state_e       state_d;
    // data words still to store
    sgdma_pkg::cell_cnt_t          rem_q;
    logic                          req_q;
    logic [sgdma_pkg::LEN_W-1:0]   hdr_len;
    sgdma_pkg::cell_cnt_t          data_cells;
    logic                          src_ok;
    logic                          head_go;
    logic                          body_go;

    ////////////////////
    // header decode
    ////////////////////

    // only meaningful while i_dat holds the header
    assign hdr_len = i_dat[sgdma_pkg::LEN_MSB:sgdma_pkg::LEN_LSB];
    // a partial cell still takes a whole word
    assign data_cells = sgdma_pkg::cell_cnt_t'(
        (int'(hdr_len) + sgdma_pkg::CELL_BYTES - 1) / sgdma_pkg::CELL_BYTES);
    // header word counts too
    assign o_total_cells = data_cells + sgdma_pkg::cell_cnt_t'(1);

    ////////////////////
    // word movement
    ////////////////////

    // a word needs both a payload and an address
    assign src_ok  = !i_empty && !i_fp_empty;
    // head also waits for room in the crossbar
    assign head_go = (state_q == sgdma_pkg::ST_HEAD) && src_ok && !i_cb_full;
    assign body_go = (state_q == sgdma_pkg::ST_BODY) && src_ok;

    // FWFT on both sides so write and pop share the cycle
    assign o_mmu_wr_en   = head_go || body_go;
    assign o_rd_en       = o_mmu_wr_en;
    assign o_fp_pop      = o_mmu_wr_en;
    assign o_mmu_wr_addr = i_fp_head;
    assign o_mmu_wr_dat  = i_dat;
    assign o_mmu_wr_req  = req_q;
    assign o_mmu_wr_done = (state_q == sgdma_pkg::ST_DONE);
    assign o_hdr_stored  = head_go;
    assign o_cb_wr_en    = head_go;

    // dispatch built straight from the head word
    always_comb begin
        o_cb_din.first_addr = i_fp_head;
        o_cb_din.cells      = o_total_cells;
        o_cb_din.qos        = i_dat[sgdma_pkg::QOS_W-1:0];
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            sgdma_pkg::ST_IDLE: begin
                if (i_locked && src_ok) begin
                    state_d = sgdma_pkg::ST_REQ;
                end
            end
            sgdma_pkg::ST_REQ: begin
                if (i_mmu_wr_ready) begin
                    state_d = sgdma_pkg::ST_HEAD;
                end
            end
            sgdma_pkg::ST_HEAD: begin
                // header-only packet skips the body
                if (head_go) begin
                    state_d = (data_cells == '0) ? sgdma_pkg::ST_DONE : sgdma_pkg::ST_BODY;
                end
            end
            sgdma_pkg::ST_BODY: begin
                if (body_go && rem_q == sgdma_pkg::cell_cnt_t'(1)) begin
                    state_d = sgdma_pkg::ST_DONE;
                end
            end
            default: begin
                state_d = sgdma_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= sgdma_pkg::ST_IDLE;
            req_q   <= 1'b0;
            rem_q   <= '0;
        end else begin
            state_q <= state_d;
            // request rises with the packet and drops once ready is seen
            if (state_q == sgdma_pkg::ST_IDLE && state_d == sgdma_pkg::ST_REQ) begin
                req_q <= 1'b1;
            end else if (state_q == sgdma_pkg::ST_REQ && i_mmu_wr_ready) begin
                req_q <= 1'b0;
            end
            if (head_go) begin
                rem_q <= data_cells;
            end else if (body_go) begin
                rem_q <= rem_q - sgdma_pkg::cell_cnt_t'(1);
            end
        end
    end

    // the body is left on its last word and never sees a zero count
    a_body_has_words: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        state_q == sgdma_pkg::ST_BODY |-> rem_q != '0);

    // memory writes only once the request has been answered
    a_no_req_in_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_mmu_wr_en |-> !o_mmu_wr_req);

endmodule

/* hdl/refill_requester.sv */
`timescale 1ns/1ps

module refill_requester (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_hdr_stored,
    input  sgdma_pkg::cell_cnt_t  i_total_cells,
    input  logic                  i_mmu_malloc_done,
    output logic                  o_aply_req,
    output sgdma_pkg::cell_cnt_t  o_length
);

    sgdma_pkg::refill_state_e state_q;
    sgdma_pkg::cell_cnt_t     length_q;

    assign o_aply_req = (state_q != sgdma_pkg::RF_IDLE);
    assign o_length   = length_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= sgdma_pkg::RF_IDLE;
        end else begin
            case (state_q)
                sgdma_pkg::RF_IDLE: begin
                    if (i_hdr_stored) begin
                        state_q <= sgdma_pkg::RF_ISSUE;
                    end
                end
                // mmu cannot answer in the cycle it first sees the request
                sgdma_pkg::RF_ISSUE: begin
                    state_q <= sgdma_pkg::RF_WAIT;
                end
                sgdma_pkg::RF_WAIT: begin
                    if (i_mmu_malloc_done) begin
                        state_q <= sgdma_pkg::RF_IDLE;
                    end
                end
                default: begin
                    state_q <= sgdma_pkg::RF_IDLE;
                end
            endcase
        end
    end

    // word count taken with the header
    always_ff @(posedge i_clk) begin
        if (state_q == sgdma_pkg::RF_IDLE && i_hdr_stored) begin
            length_q <= i_total_cells;
        end
    end

    // a new header before malloc done would overwrite the pending count
    a_one_refill: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_hdr_stored |-> !o_aply_req);

endmodule

/* hdl/port_sgdma_top.sv */
`timescale 1ns/1ps

module port_sgdma_top #(
    parameter sgdma_pkg::port_id_t PORT_ID = '0
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_locked,
    // ingress FIFO, first word falls through
    input  sgdma_pkg::data_t      i_dat,
    input  logic                  i_empty,
    output logic                  o_rd_en,
    // crossbar
    output sgdma_pkg::dispatch_t  o_cb_din,
    output logic                  o_cb_wr_en,
    input  logic                  i_cb_full,
    // memory manager write side
    output logic                  o_mmu_wr_req,
    input  logic                  i_mmu_wr_ready,
    output logic                  o_mmu_wr_en,
    output sgdma_pkg::addr_t      o_mmu_wr_addr,
    output sgdma_pkg::data_t      o_mmu_wr_dat,
    output logic                  o_mmu_wr_done,
    // refill and recycling
    input  logic                  i_mmu_malloc_done,
    input  logic                  i_fp_wr_en,
    input  sgdma_pkg::addr_t      i_fp_wr_dat,
    output logic                  o_aply_req,
    output sgdma_pkg::cell_cnt_t  o_length
);

    // free list between init/recycle and the store FSM
    sgdma_pkg::addr_t     fp_head;
    logic                 fp_empty;
    logic                 fp_full;
    logic                 fp_pop;
    logic                 fp_push;
    sgdma_pkg::addr_t     fp_push_addr;
    // head stored, kicks off the refill request
    logic                 hdr_stored;
    sgdma_pkg::cell_cnt_t total_cells;

    cell_store_fsm cell_store_fsm_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_locked       (i_locked),
        .i_dat          (i_dat),
        .i_empty        (i_empty),
        .i_cb_full      (i_cb_full),
        .i_mmu_wr_ready (i_mmu_wr_ready),
        .i_fp_head      (fp_head),
        .i_fp_empty     (fp_empty),
        .o_rd_en        (o_rd_en),
        .o_fp_pop       (fp_pop),
        .o_cb_din       (o_cb_din),
        .o_cb_wr_en     (o_cb_wr_en),
        .o_mmu_wr_req   (o_mmu_wr_req),
        .o_mmu_wr_en    (o_mmu_wr_en),
        .o_mmu_wr_addr  (o_mmu_wr_addr),
        .o_mmu_wr_dat   (o_mmu_wr_dat),
        .o_mmu_wr_done  (o_mmu_wr_done),
        .o_hdr_stored   (hdr_stored),
        .o_total_cells  (total_cells)
    );

    refill_requester refill_requester_inst (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_hdr_stored      (hdr_stored),
        .i_total_cells     (total_cells),
        .i_mmu_malloc_done (i_mmu_malloc_done),
        .o_aply_req        (o_aply_req),
        .o_length          (o_length)
    );

    free_list_init #(
        .PORT_ID (PORT_ID)
    ) free_list_init_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_locked    (i_locked),
        .i_fp_full   (fp_full),
        .i_fp_wr_en  (i_fp_wr_en),
        .i_fp_wr_dat (i_fp_wr_dat),
        .o_push      (fp_push),
        .o_push_addr (fp_push_addr)
    );

    free_ptr_fifo free_ptr_fifo_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_push      (fp_push),
        .i_push_addr (fp_push_addr),
        .i_pop       (fp_pop),
        .o_head      (fp_head),
        .o_full      (fp_full),
        .o_empty     (fp_empty)
    );

endmodule

/* dv/tb_port_sgdma.sv */
`timescale 1ns/1ps

module tb_port_sgdma;

    localparam sgdma_pkg::port_id_t PORT_ID = 4'd3;

    logic                 i_clk = 1'b0;
    logic                 i_rst_n;
    logic                 i_locked;
    sgdma_pkg::data_t     i_dat;
    logic                 i_empty;
    logic                 i_cb_full = 1'b0;
    logic                 i_mmu_wr_ready = 1'b0;
    logic                 i_mmu_malloc_done = 1'b0;
    logic                 i_fp_wr_en = 1'b0;
    sgdma_pkg::addr_t     i_fp_wr_dat = '0;
    logic                 o_rd_en;
    sgdma_pkg::dispatch_t o_cb_din;
    logic                 o_cb_wr_en;
    logic                 o_mmu_wr_req;
    logic                 o_mmu_wr_en;
    sgdma_pkg::addr_t     o_mmu_wr_addr;
    sgdma_pkg::data_t     o_mmu_wr_dat;
    logic                 o_mmu_wr_done;
    logic                 o_aply_req;
    sgdma_pkg::cell_cnt_t o_length;

    // stim columns with one entry per packet
    int st_len[$];
    int st_dest[$];
    int st_prio[$];
    int st_cbf[$];
    int st_gap[$];
    int st_cnt[$];
    int n_pkts = 0;
    // input FIFO, expected words, free list model, addresses awaiting return
    sgdma_pkg::data_t in_q[$];
    sgdma_pkg::data_t exp_dat_q[$];
    sgdma_pkg::addr_t fl_model[$];
    sgdma_pkg::addr_t used_q[$];
    sgdma_pkg::addr_t ret_q[$];
    // current packet as set by the main sequence
    int cur_cnt = 0;
    int cur_dest = 0;
    int cur_prio = 0;
    int cur_cbf = 0;
    // clock loss with a header waiting, once init is over
    logic relock_done = 1'b0;
    // sampled at the falling edge
    logic rd_seen = 1'b0;
    logic req_seen = 1'b0;
    logic req_prev = 1'b0;
    logic aply_seen = 1'b0;
    logic mal_seen = 1'b0;
    logic wr_prev = 1'b0;
    // counters
    int err_cnt = 0;
    int wr_cnt = 0;
    int cb_cnt = 0;
    int done_cnt = 0;
    int word_cnt = 0;
    int aply_rises = 0;
    int lock_cnt = 0;
    int rdy_wait = 0;
    int cb_hold = 0;
    int mal_cnt = 0;
    int ret_gap = 0;
    sgdma_pkg::data_t     exp_d;
    sgdma_pkg::addr_t     exp_a;
    sgdma_pkg::dispatch_t exp_disp;

    always #50 i_clk = ~i_clk;

    port_sgdma_top #(
        .PORT_ID (PORT_ID)
    ) port_sgdma_top_inst (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_locked          (i_locked),
        .i_dat             (i_dat),
        .i_empty           (i_empty),
        .o_rd_en           (o_rd_en),
        .o_cb_din          (o_cb_din),
        .o_cb_wr_en        (o_cb_wr_en),
        .i_cb_full         (i_cb_full),
        .o_mmu_wr_req      (o_mmu_wr_req),
        .i_mmu_wr_ready    (i_mmu_wr_ready),
        .o_mmu_wr_en       (o_mmu_wr_en),
        .o_mmu_wr_addr     (o_mmu_wr_addr),
        .o_mmu_wr_dat      (o_mmu_wr_dat),
        .o_mmu_wr_done     (o_mmu_wr_done),
        .i_mmu_malloc_done (i_mmu_malloc_done),
        .i_fp_wr_en        (i_fp_wr_en),
        .i_fp_wr_dat       (i_fp_wr_dat),
        .o_aply_req        (o_aply_req),
        .o_length          (o_length)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // FWFT view of the input queue
    task automatic refresh_fifo();
        i_empty = (in_q.size() == 0);
        i_dat   = (in_q.size() > 0) ? in_q[0] : '0;
    endtask

    // one clock, then apply the pop seen in the cycle just ended
    task automatic next_cycle();
        @(posedge i_clk);
        #1;
        if (rd_seen && in_q.size() > 0) begin
            void'(in_q.pop_front());
        end
        refresh_fifo();
    endtask

    task automatic read_stim();
        int    fd;
        int    r;
        int    a;
        int    b;
        int    c;
        int    d;
        int    e;
        int    f;
        string line;
        fd = $fopen("dv/port_sgdma_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file");
            err_cnt++;
            return;
        end
        while (!$feof(fd)) begin
            r = $fgets(line, fd);
            // '#' lines are comments
            if (r > 0 && line.getc(0) != "#") begin
                if ($sscanf(line, "%d %d %d %d %d %d", a, b, c, d, e, f) == 6) begin
                    st_len.push_back(a);
                    st_dest.push_back(b);
                    st_prio.push_back(c);
                    st_cbf.push_back(d);
                    st_gap.push_back(e);
                    st_cnt.push_back(f);
                end
            end
        end
        $fclose(fd);
        n_pkts = st_len.size();
    endtask

    ////////////////////
    // memory manager, crossbar and recycling models
    ////////////////////

    always @(posedge i_clk) begin
        #1;
        if (i_locked) begin
            lock_cnt++;
        end
        // ready stays low for a few cycles of the request and then rises
        if (req_seen) begin
            if (rdy_wait < 3) begin
                rdy_wait++;
                i_mmu_wr_ready = 1'b0;
            end else begin
                i_mmu_wr_ready = 1'b1;
            end
        end else begin
            rdy_wait = 0;
            i_mmu_wr_ready = 1'b0;
        end
        // crossbar full window covers the head cycle
        if (req_seen && !req_prev && cur_cbf != 0) begin
            cb_hold = 7;
        end
        req_prev  = req_seen;
        i_cb_full = (cb_hold > 0);
        if (cb_hold > 0) begin
            cb_hold--;
        end
        // malloc done two cycles into the refill request
        if (i_mmu_malloc_done) begin
            i_mmu_malloc_done = 1'b0;
            mal_cnt = 0;
        end else if (aply_seen) begin
            mal_cnt++;
            if (mal_cnt == 2) begin
                i_mmu_malloc_done = 1'b1;
            end
        end else begin
            mal_cnt = 0;
        end
        // one return every 4 cycles once init is surely over
        if (lock_cnt >= 140 && ret_q.size() > 0 && ret_gap == 0) begin
            i_fp_wr_en  = 1'b1;
            i_fp_wr_dat = ret_q.pop_front();
            fl_model.push_back(i_fp_wr_dat);
            ret_gap = 3;
        end else begin
            i_fp_wr_en = 1'b0;
            if (ret_gap > 0) begin
                ret_gap--;
            end
        end
    end

    ////////////////////
    // output monitor
    ////////////////////

    always @(negedge i_clk) begin
        if (i_rst_n) begin
            if (!i_locked && (o_rd_en || o_mmu_wr_req || o_mmu_wr_en || o_cb_wr_en)) begin
                $display("DUT active while i_locked is low");
                err_cnt++;
            end
            if (i_cb_full && (o_cb_wr_en || o_mmu_wr_en)) begin
                $display("write issued while the crossbar is full");
                err_cnt++;
            end
            if (o_rd_en && i_empty) begin
                $display("input FIFO popped while empty");
                err_cnt++;
            end
            if (o_mmu_wr_en && o_mmu_wr_req) begin
                $display("memory write while the write request is still high");
                err_cnt++;
            end
            // dispatch comes with the head word only
            if (o_cb_wr_en) begin
                cb_cnt++;
                exp_disp.first_addr = (fl_model.size() > 0) ? fl_model[0] : '0;
                exp_disp.cells      = sgdma_pkg::cell_cnt_t'(cur_cnt);
                exp_disp.qos        = {3'(cur_prio), 4'(cur_dest)};
                if (o_cb_din !== exp_disp) begin
                    $display("Error: o_cb_din is 0x%h, expected 0x%h", o_cb_din, exp_disp);
                    err_cnt++;
                end
                if (!o_mmu_wr_en || wr_cnt != 0) begin
                    $display("crossbar push not in the head write cycle");
                    err_cnt++;
                end
            end
            if (o_mmu_wr_en) begin
                if (exp_dat_q.size() == 0 || fl_model.size() == 0) begin
                    $display("memory write with no word or address expected");
                    err_cnt++;
                end else begin
                    exp_d = exp_dat_q.pop_front();
                    exp_a = fl_model.pop_front();
                    if (o_mmu_wr_dat !== exp_d) begin
                        $display("Error: o_mmu_wr_dat is 0x%h, expected 0x%h", o_mmu_wr_dat, exp_d);
                        err_cnt++;
                    end
                    if (o_mmu_wr_addr !== exp_a) begin
                        $display("Error: o_mmu_wr_addr is 0x%h, expected 0x%h",
                            o_mmu_wr_addr, exp_a);
                        err_cnt++;
                    end
                    used_q.push_back(exp_a);
                end
                wr_cnt++;
                word_cnt++;
            end
            if (o_mmu_wr_done) begin
                if (wr_cnt != cur_cnt) begin
                    $display("Error: o_mmu_wr_en count is 0x%h, expected 0x%h", wr_cnt, cur_cnt);
                    err_cnt++;
                end
                if (!wr_prev) begin
                    $display("o_mmu_wr_done not one cycle after the last write");
                    err_cnt++;
                end
                if (cb_cnt != 1) begin
                    $display("packet done without exactly one crossbar push");
                    err_cnt++;
                end
                // a stored packet's addresses go back to the memory manager
                while (used_q.size() > 0) begin
                    ret_q.push_back(used_q.pop_front());
                end
                wr_cnt = 0;
                cb_cnt = 0;
                done_cnt++;
            end
            if (o_aply_req) begin
                if (!aply_seen) begin
                    aply_rises++;
                end
                if (o_length !== sgdma_pkg::cell_cnt_t'(cur_cnt)) begin
                    $display("Error: o_length is 0x%h, expected 0x%h", o_length, cur_cnt);
                    err_cnt++;
                end
            end else if (aply_seen && !mal_seen) begin
                $display("refill request dropped without malloc done");
                err_cnt++;
            end
        end
        rd_seen   = o_rd_en;
        req_seen  = o_mmu_wr_req;
        aply_seen = o_aply_req;
        mal_seen  = i_mmu_malloc_done;
        wr_prev   = o_mmu_wr_en;
    end

    // 2000 cycles per packet line
    initial begin
        wait (n_pkts > 0);
        repeat (n_pkts * 2000) @(posedge i_clk);
        $display("timeout, packets did not complete in time");
        $display("Verification failed");
        $finish;
    end

    initial begin
        logic [31:0]      rnd;
        sgdma_pkg::data_t pkt[$];
        sgdma_pkg::data_t w;
        i_rst_n  = 1'b0;
        i_locked = 1'b0;
        i_dat    = '0;
        i_empty  = 1'b1;
        rnd      = 32'heba6_0c10;
        // init order of the free list with the port id on top
        for (int i = 0; i < sgdma_pkg::FL_INIT_CNT; i++) begin
            fl_model.push_back({PORT_ID, 5'b0, 7'(i)});
        end
        read_stim();
        repeat (10) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        @(negedge i_clk);
        if (o_rd_en || o_mmu_wr_req || o_mmu_wr_en || o_mmu_wr_done || o_cb_wr_en
                || o_aply_req) begin
            $display("control outputs not low after reset");
            err_cnt++;
        end
        repeat (5) next_cycle();
        for (int k = 0; k < n_pkts; k++) begin
            cur_cnt  = st_cnt[k];
            cur_dest = st_dest[k];
            cur_prio = st_prio[k];
            cur_cbf  = st_cbf[k];
            // addresses are free by now so only i_locked holds the header back
            if (!relock_done && lock_cnt >= 140) begin
                relock_done = 1'b1;
                i_locked    = 1'b0;
            end
            // header with random upper bits, then random payload
            rnd = xorshift32(rnd);
            w = rnd;
            w[sgdma_pkg::LEN_MSB:sgdma_pkg::LEN_LSB] = 11'(st_len[k]);
            w[6:4]   = 3'(st_prio[k]);
            w[3:0]   = 4'(st_dest[k]);
            w[21:18] = PORT_ID;
            pkt.delete();
            pkt.push_back(w);
            for (int j = 1; j < cur_cnt; j++) begin
                rnd = xorshift32(rnd);
                pkt.push_back(rnd);
            end
            for (int j = 0; j < pkt.size(); j++) begin
                pkt_words_expected: begin
                    exp_dat_q.push_back(pkt[j]);
                end
            end
            for (int j = 0; j < pkt.size(); j++) begin
                // gap lets the FIFO drain mid-packet
                if (st_gap[k] != 0 && j == pkt.size() / 2 && j > 0) begin
                    while (in_q.size() > 0) begin
                        next_cycle();
                    end
                    repeat (4) next_cycle();
                end
                in_q.push_back(pkt[j]);
                refresh_fifo();
                next_cycle();
                // header waits a while before the clock locks
                if (!i_locked) begin
                    repeat (5) next_cycle();
                    i_locked = 1'b1;
                end
            end
            // one packet in flight and the refill settled before the next
            while (done_cnt <= k || aply_seen) begin
                next_cycle();
            end
        end
        repeat (5) next_cycle();
        if (aply_rises != n_pkts) begin
            $display("Error: o_aply_req rises 0x%h, expected 0x%h", aply_rises, n_pkts);
            err_cnt++;
        end
        if (in_q.size() != 0 || exp_dat_q.size() != 0) begin
            $display("words left unstored at the end of the run");
            err_cnt++;
        end
        if (!relock_done) begin
            $display("the clock was never lost with a header waiting");
            err_cnt++;
        end
        if (n_pkts == 0) begin
            $display("no stimulus lines were read");
            err_cnt++;
        end
        $display("packets %0d, words %0d, errors %0d", done_cnt, word_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* dv/port_sgdma_stim.txt */
# columns: byte_length dest_port priority cb_full_at_head input_gap expected_total_cells
# expected_total_cells = ceil(byte_length / 16) + 1 for the header word
0 1 0 0 0 1
1 2 1 0 0 2
16 4 2 1 0 2
17 5 3 0 1 3
100 6 4 0 0 8
640 7 5 1 1 41
600 8 6 0 1 39
500 9 7 1 0 33
255 10 1 0 1 17
48 11 2 0 0 4
2016 12 3 1 1 127
33 13 0 0 0 4
32 14 4 1 0 3

/* port_sgdma.f */
common/sgdma_pkg.sv
free_list/free_ptr_fifo.sv
free_list/free_list_init.sv
hdl/cell_store_fsm.sv
hdl/refill_requester.sv
hdl/port_sgdma_top.sv
dv/tb_port_sgdma.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f port_sgdma.f --top-module tb_port_sgdma -o tb_port_sgdma
./obj_dir/tb_port_sgdma > sim.log 2>&1 || true
cat sim.log
if grep -q "^Verification passed$" sim.log; then
    echo "simulation PASS"
else
    echo "simulation FAIL"
    exit 1
fi
